/* rtl/pwo_pkg.sv */
// ====================================================================
// Pointwise-operation engine shared definitions
// Coefficient and memory word geometry, the ML-DSA modulus, pipeline
// latencies, the memory request format and the per-word lane command
// ====================================================================

package pwo_pkg;

    // ====================================================================
    // Geometry
    localparam int PWO_COEFF_W = 23;
    localparam int PWO_SLOT_W  = 24;
    localparam int PWO_LANES   = 4;
    localparam int PWO_WORD_W  = PWO_SLOT_W * PWO_LANES;
    localparam int PWO_ADDR_W  = 15;

    // ML-DSA prime, 2^23 - 2^13 + 1
    localparam logic [PWO_COEFF_W-1:0] PWO_Q = 23'd8380417;

    // ====================================================================
    // Latencies in cycles
    localparam int PWO_MULT_LATENCY = 3;
    localparam int PWO_LANE_LATENCY = 4;
    // Memory read, operand register, then the lane
    localparam int PWO_RD_TO_WR     = 1 + 1 + PWO_LANE_LATENCY;

    typedef enum logic [1:0] {
        PWO_PWM = 2'd0,
        PWO_PWA = 2'd1,
        PWO_PWS = 2'd2
    } pwo_mode_e;

    typedef enum logic [1:0] {
        RW_IDLE  = 2'b00,
        RW_READ  = 2'b01,
        RW_WRITE = 2'b10
    } pwo_rw_e;

    // Memory request, active when the code is not idle
    typedef struct packed {
        pwo_rw_e                rd_wr_en;
        logic [PWO_ADDR_W-1:0]  addr;
    } pwo_mem_req_t;

    // Command that travels with each word into the lanes
    typedef struct packed {
        logic       valid;
        pwo_mode_e  op;
        logic       acc_en;
    } pwo_cmd_t;

endpackage

/* rtl/pwo_mod_mult.sv */
// ====================================================================
// Pipelined modular multiplier
// Registers the full product, then folds it down with
// 2^23 = 2^13 - 1 (mod q) and finishes with one conditional subtract
// ====================================================================

module pwo_mod_mult (
    input  logic                             clk,
    input  logic                             reset_n,
    input  logic [pwo_pkg::PWO_COEFF_W-1:0]  a_i,
    input  logic [pwo_pkg::PWO_COEFF_W-1:0]  b_i,
    output logic [pwo_pkg::PWO_COEFF_W-1:0]  p_o
);

    localparam int W    = pwo_pkg::PWO_COEFF_W;
    localparam int S    = 13;
    // Bounds of each fold: <2^37, <2^28, <2^24 (the last one below 2q)
    localparam int F1_W = 37;
    localparam int F2_W = 28;
    localparam int F3_W = 24;

    logic [2*W-1:0]  prod_q;
    logic [F1_W-1:0] fold1;
    logic [F2_W-1:0] fold2;
    logic [F2_W-1:0] fold2_q;
    logic [F3_W-1:0] fold3;
    logic [F3_W-1:0] fold3_red;

    // Each fold replaces hi*2^23 by hi*2^13 - hi
    always_comb begin
        fold1 = F1_W'({prod_q[2*W-1:W], S'(0)}) - F1_W'(prod_q[2*W-1:W])
              + F1_W'(prod_q[W-1:0]);
        fold2 = F2_W'({fold1[F1_W-1:W], S'(0)}) - F2_W'(fold1[F1_W-1:W])
              + F2_W'(fold1[W-1:0]);
        fold3 = F3_W'({fold2_q[F2_W-1:W], S'(0)}) - F3_W'(fold2_q[F2_W-1:W])
              + F3_W'(fold2_q[W-1:0]);
        fold3_red = fold3 - F3_W'(pwo_pkg::PWO_Q);
    end

    // Three stages, each may hold a different product
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            prod_q  <= '0;
            fold2_q <= '0;
            p_o     <= '0;
        end else begin
            prod_q  <= a_i * b_i;
            fold2_q <= fold2;
            if (fold3 >= F3_W'(pwo_pkg::PWO_Q)) begin
                p_o <= fold3_red[W-1:0];
            end else begin
                p_o <= fold3[W-1:0];
            end
        end
    end

endmodule

/* rtl/pwo_lane.sv */
// ====================================================================
// Single coefficient lane
// Multiply, add or subtract mod q with optional accumulate; all
// operations share one final modular adder so latency is constant
// ====================================================================

module pwo_lane (
    input  logic                             clk,
    input  logic                             reset_n,
    input  pwo_pkg::pwo_cmd_t                cmd_i,
    input  logic [pwo_pkg::PWO_COEFF_W-1:0]  a_i,
    input  logic [pwo_pkg::PWO_COEFF_W-1:0]  b_i,
    input  logic [pwo_pkg::PWO_COEFF_W-1:0]  c_i,
    output logic [pwo_pkg::PWO_COEFF_W-1:0]  res_o
);

    localparam int W = pwo_pkg::PWO_COEFF_W;
    localparam int D = pwo_pkg::PWO_MULT_LATENCY;

    logic [W-1:0]                 prod;
    logic [W-1:0]                 y_in;
    pwo_pkg::pwo_cmd_t [D-1:0]    cmd_sr;
    logic [D-1:0][W-1:0]          x_sr;
    logic [D-1:0][W-1:0]          y_sr;
    logic [W-1:0]                 x_fin;
    logic [W:0]                   sum;
    logic [W:0]                   sum_red;

    pwo_mod_mult u_mod_mult (
        .clk     (clk),
        .reset_n (reset_n),
        .a_i     (a_i),
        .b_i     (b_i),
        .p_o     (prod)
    );

    // Second adder operand; q - b turns subtract into add
    always_comb begin
        unique case (cmd_i.op)
            pwo_pkg::PWO_PWA: y_in = b_i;
            pwo_pkg::PWO_PWS: y_in = pwo_pkg::PWO_Q - b_i;
            default:          y_in = cmd_i.acc_en ? c_i : '0;
        endcase
    end

    // Command follows the multiplier stages
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            cmd_sr <= '0;
        end else begin
            cmd_sr <= {cmd_sr[D-2:0], cmd_i};
        end
    end

    // Operands padded to the multiplier latency
    always_ff @(posedge clk) begin
        x_sr <= {x_sr[D-2:0], a_i};
        y_sr <= {y_sr[D-2:0], y_in};
    end

    // Final add, both inputs below q so one correction is enough
    always_comb begin
        x_fin   = (cmd_sr[D-1].op == pwo_pkg::PWO_PWM) ? prod : x_sr[D-1];
        sum     = {1'b0, x_fin} + {1'b0, y_sr[D-1]};
        sum_red = sum - (W+1)'(pwo_pkg::PWO_Q);
    end

    always_ff @(posedge clk) begin
        if (cmd_sr[D-1].valid) begin
            if (sum >= (W+1)'(pwo_pkg::PWO_Q)) begin
                res_o <= sum_red[W-1:0];
            end else begin
                res_o <= sum[W-1:0];
            end
        end
    end

endmodule

/* rtl/pwo_ctrl.sv */
// ====================================================================
// Pointwise-operation sequencer
// Latches the operation on start, issues one read per cycle, and
// lines up the lane command and the c write with each word in flight
// ====================================================================

module pwo_ctrl #(
    parameter int NUM_WORDS = 64
) (
    input  logic                            clk,
    input  logic                            reset_n,
    input  logic                            enable_i,
    input  pwo_pkg::pwo_mode_e              mode_i,
    input  logic                            accumulate_i,
    input  logic [pwo_pkg::PWO_ADDR_W-1:0]  a_base_i,
    input  logic [pwo_pkg::PWO_ADDR_W-1:0]  b_base_i,
    input  logic [pwo_pkg::PWO_ADDR_W-1:0]  c_base_i,
    output pwo_pkg::pwo_mem_req_t           a_rd_req_o,
    output pwo_pkg::pwo_mem_req_t           b_rd_req_o,
    output pwo_pkg::pwo_mem_req_t           c_rd_req_o,
    output pwo_pkg::pwo_mem_req_t           c_wr_req_o,
    output pwo_pkg::pwo_cmd_t               cmd_o,
    output logic                            busy_o,
    output logic                            done_o
);

    localparam int AW      = pwo_pkg::PWO_ADDR_W;
    localparam int IDX_W   = (NUM_WORDS > 1) ? $clog2(NUM_WORDS) : 1;
    localparam int DLY     = pwo_pkg::PWO_RD_TO_WR;
    // Read data lands one cycle later, then the operand register
    localparam int CMD_TAP = 1;
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(NUM_WORDS - 1);

    logic                      start;
    logic                      last_wr;
    logic                      issue_q;
    logic                      acc_q;
    pwo_pkg::pwo_mode_e        mode_q;
    logic [IDX_W-1:0]          cnt_q;
    logic [AW-1:0]             a_base_q;
    logic [AW-1:0]             b_base_q;
    logic [AW-1:0]             c_base_q;
    logic [DLY-1:0]            vld_sr;
    logic [DLY-1:0][IDX_W-1:0] idx_sr;

    assign start   = enable_i && !busy_o;
    assign last_wr = vld_sr[DLY-1] && (idx_sr[DLY-1] == LAST_IDX);

    // ====================================================================
    // Start, word issue and completion
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            busy_o  <= 1'b0;
            done_o  <= 1'b0;
            issue_q <= 1'b0;
            acc_q   <= 1'b0;
            mode_q  <= pwo_pkg::PWO_PWM;
            cnt_q   <= '0;
            vld_sr  <= '0;
        end else begin
            done_o <= last_wr;
            vld_sr <= {vld_sr[DLY-2:0], issue_q};
            if (start) begin
                busy_o  <= 1'b1;
                issue_q <= 1'b1;
                cnt_q   <= '0;
                mode_q  <= mode_i;
                // Accumulate only has a meaning for multiply
                acc_q   <= accumulate_i && (mode_i == pwo_pkg::PWO_PWM);
            end else begin
                if (issue_q) begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == LAST_IDX) begin
                        issue_q <= 1'b0;
                    end
                end
                if (last_wr) begin
                    busy_o <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            a_base_q <= a_base_i;
            b_base_q <= b_base_i;
            c_base_q <= c_base_i;
        end
        idx_sr <= {idx_sr[DLY-2:0], cnt_q};
    end

    // ====================================================================
    // Memory requests and lane command
    always_comb begin
        a_rd_req_o.rd_wr_en = issue_q ? pwo_pkg::RW_READ : pwo_pkg::RW_IDLE;
        a_rd_req_o.addr     = a_base_q + AW'(cnt_q);
        b_rd_req_o.rd_wr_en = issue_q ? pwo_pkg::RW_READ : pwo_pkg::RW_IDLE;
        b_rd_req_o.addr     = b_base_q + AW'(cnt_q);
        c_rd_req_o.rd_wr_en = (issue_q && acc_q) ? pwo_pkg::RW_READ : pwo_pkg::RW_IDLE;
        c_rd_req_o.addr     = c_base_q + AW'(cnt_q);
        c_wr_req_o.rd_wr_en = vld_sr[DLY-1] ? pwo_pkg::RW_WRITE : pwo_pkg::RW_IDLE;
        c_wr_req_o.addr     = c_base_q + AW'(idx_sr[DLY-1]);
        cmd_o.valid         = vld_sr[CMD_TAP];
        cmd_o.op            = mode_q;
        cmd_o.acc_en        = acc_q;
    end

endmodule

/* rtl/pwo_top.sv */
// ====================================================================
// Pointwise-operation engine top level
// Sequencer plus four coefficient lanes; memory words are registered,
// split into 24-bit slots and the lane results packed back for c
// ====================================================================

module pwo_top #(
    parameter int NUM_WORDS = 64
) (
    input  logic                            clk,
    input  logic                            reset_n,
    input  logic                            pwo_enable_i,
    input  pwo_pkg::pwo_mode_e              pwo_mode_i,
    input  logic                            accumulate_i,
    input  logic [pwo_pkg::PWO_ADDR_W-1:0]  a_base_i,
    input  logic [pwo_pkg::PWO_ADDR_W-1:0]  b_base_i,
    input  logic [pwo_pkg::PWO_ADDR_W-1:0]  c_base_i,
    input  logic [pwo_pkg::PWO_WORD_W-1:0]  a_rd_data_i,
    input  logic [pwo_pkg::PWO_WORD_W-1:0]  b_rd_data_i,
    input  logic [pwo_pkg::PWO_WORD_W-1:0]  c_rd_data_i,
    output pwo_pkg::pwo_mem_req_t           a_rd_req_o,
    output pwo_pkg::pwo_mem_req_t           b_rd_req_o,
    output pwo_pkg::pwo_mem_req_t           c_rd_req_o,
    output pwo_pkg::pwo_mem_req_t           c_wr_req_o,
    output logic [pwo_pkg::PWO_WORD_W-1:0]  c_wr_data_o,
    output logic                            busy_o,
    output logic                            done_o
);

    localparam int SW = pwo_pkg::PWO_SLOT_W;
    localparam int CW = pwo_pkg::PWO_COEFF_W;
    localparam int WW = pwo_pkg::PWO_WORD_W;
    localparam int NL = pwo_pkg::PWO_LANES;

    pwo_pkg::pwo_cmd_t      lane_cmd;
    logic [WW-1:0]          a_q;
    logic [WW-1:0]          b_q;
    logic [WW-1:0]          c_q;
    logic [NL-1:0][CW-1:0]  lane_res;

    pwo_ctrl #(
        .NUM_WORDS (NUM_WORDS)
    ) u_ctrl (
        .clk          (clk),
        .reset_n      (reset_n),
        .enable_i     (pwo_enable_i),
        .mode_i       (pwo_mode_i),
        .accumulate_i (accumulate_i),
        .a_base_i     (a_base_i),
        .b_base_i     (b_base_i),
        .c_base_i     (c_base_i),
        .a_rd_req_o   (a_rd_req_o),
        .b_rd_req_o   (b_rd_req_o),
        .c_rd_req_o   (c_rd_req_o),
        .c_wr_req_o   (c_wr_req_o),
        .cmd_o        (lane_cmd),
        .busy_o       (busy_o),
        .done_o       (done_o)
    );

    // Operand registers, aligned with the lane command
    always_ff @(posedge clk) begin
        a_q <= a_rd_data_i;
        b_q <= b_rd_data_i;
        c_q <= c_rd_data_i;
    end

    for (genvar i = 0; i < NL; i++) begin : g_lane
        pwo_lane u_lane (
            .clk     (clk),
            .reset_n (reset_n),
            .cmd_i   (lane_cmd),
            .a_i     (a_q[i*SW +: CW]),
            .b_i     (b_q[i*SW +: CW]),
            .c_i     (c_q[i*SW +: CW]),
            .res_o   (lane_res[i])
        );

        // Spare top bit of every slot stays zero
        assign c_wr_data_o[i*SW +: SW] = {{(SW-CW){1'b0}}, lane_res[i]};
    end

endmodule

/* verif/pwo_tb_assert.sv */
// ======================================================================
// Protocol assertions for the pointwise-operation engine
// Done pulse width, requests only while busy, write port direction
// and c reads limited to multiply with accumulate
// ======================================================================

module pwo_tb_assert (
    input logic                  clk,
    input logic                  reset_n,
    input logic                  enable_i,
    input pwo_pkg::pwo_mode_e    mode_i,
    input logic                  accumulate_i,
    input logic                  busy_i,
    input logic                  done_i,
    input pwo_pkg::pwo_mem_req_t a_rd_req_i,
    input pwo_pkg::pwo_mem_req_t b_rd_req_i,
    input pwo_pkg::pwo_mem_req_t c_rd_req_i,
    input pwo_pkg::pwo_mem_req_t c_wr_req_i
);
    timeunit 1ns;
    timeprecision 1ps;

    int   fail_cnt = 0;
    logic acc_applies_q;
    logic any_req;

    assign any_req = (a_rd_req_i.rd_wr_en != pwo_pkg::RW_IDLE)
                  || (b_rd_req_i.rd_wr_en != pwo_pkg::RW_IDLE)
                  || (c_rd_req_i.rd_wr_en != pwo_pkg::RW_IDLE)
                  || (c_wr_req_i.rd_wr_en != pwo_pkg::RW_IDLE);

    // Mirror of the operation latched at start
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            acc_applies_q <= 1'b0;
        end else if (enable_i && !busy_i) begin
            acc_applies_q <= accumulate_i && (mode_i == pwo_pkg::PWO_PWM);
        end
    end

    done_single: assert property (@(posedge clk) disable iff (!reset_n) done_i |=> !done_i)
        else begin
            $error("done_o high for more than one cycle");
            fail_cnt = fail_cnt + 1;
        end

    idle_when_free: assert property (@(posedge clk) disable iff (!reset_n) !busy_i |-> !any_req)
        else begin
            $error("memory request while not busy");
            fail_cnt = fail_cnt + 1;
        end

    wr_port_dir: assert property (@(posedge clk) disable iff (!reset_n)
        c_wr_req_i.rd_wr_en != pwo_pkg::RW_READ)
        else begin
            $error("read code on the c write port");
            fail_cnt = fail_cnt + 1;
        end

    c_rd_acc_only: assert property (@(posedge clk) disable iff (!reset_n)
        (c_rd_req_i.rd_wr_en != pwo_pkg::RW_IDLE) |-> acc_applies_q)
        else begin
            $error("c read without multiply accumulate");
            fail_cnt = fail_cnt + 1;
        end

endmodule

bind pwo_top pwo_tb_assert u_assert (
    .clk          (clk),
    .reset_n      (reset_n),
    .enable_i     (pwo_enable_i),
    .mode_i       (pwo_mode_i),
    .accumulate_i (accumulate_i),
    .busy_i       (busy_o),
    .done_i       (done_o),
    .a_rd_req_i   (a_rd_req_o),
    .b_rd_req_i   (b_rd_req_o),
    .c_rd_req_i   (c_rd_req_o),
    .c_wr_req_i   (c_wr_req_o)
);

/* verif/pwo_tb.sv */
// ======================================================================
// Pointwise-operation engine testbench
// Memory models for a, b and c, LFSR operand data, a table of runs
// checked against a reference model, run timing and a cycle limit
// ======================================================================

module pwo_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int     NUM_WORDS  = 64;
    localparam int     DEPTH      = 512;
    localparam int     NUM_ROWS   = 5;
    localparam longint Q          = 8380417;
    // Enable cycle plus one read per word plus read to write
    localparam int     DONE_CYCLE = 1 + NUM_WORDS + 6;
    localparam int     MAX_CYCLES = NUM_ROWS * 80 + 100;

    typedef struct packed {
        pwo_pkg::pwo_mode_e mode;
        logic               acc;
        logic [14:0]        a_base;
        logic [14:0]        b_base;
        logic [14:0]        c_base;
    } row_t;

    // Row 1 accumulates onto the results of row 0
    // Rows 2 and 3 set acc and must ignore it
    // Row 4 multiplies operands near q-1
    localparam row_t ROWS [NUM_ROWS] = '{
        '{pwo_pkg::PWO_PWM, 1'b0, 15'd0,   15'd64,  15'd128},
        '{pwo_pkg::PWO_PWM, 1'b1, 15'd0,   15'd64,  15'd128},
        '{pwo_pkg::PWO_PWA, 1'b1, 15'd192, 15'd256, 15'd320},
        '{pwo_pkg::PWO_PWS, 1'b1, 15'd192, 15'd256, 15'd384},
        '{pwo_pkg::PWO_PWM, 1'b0, 15'd448, 15'd448, 15'd0}
    };

    logic                  clk = 1'b0;
    logic                  reset_n;
    logic                  pwo_enable;
    pwo_pkg::pwo_mode_e    pwo_mode;
    logic                  accumulate;
    logic [14:0]           a_base;
    logic [14:0]           b_base;
    logic [14:0]           c_base;
    logic [95:0]           a_rd_data;
    logic [95:0]           b_rd_data;
    logic [95:0]           c_rd_data;
    logic [95:0]           c_wr_data;
    pwo_pkg::pwo_mem_req_t a_rd_req;
    pwo_pkg::pwo_mem_req_t b_rd_req;
    pwo_pkg::pwo_mem_req_t c_rd_req;
    pwo_pkg::pwo_mem_req_t c_wr_req;
    logic                  busy;
    logic                  done;
    logic [95:0]           a_mem [DEPTH];
    logic [95:0]           b_mem [DEPTH];
    logic [95:0]           c_mem [DEPTH];
    logic [95:0]           c_old [DEPTH];
    logic [31:0]           lfsr;
    int                    cycle_cnt = 0;
    int                    wr_count;

    always #4 clk = ~clk;

    pwo_top #(
        .NUM_WORDS (NUM_WORDS)
    ) pwo_top_i (
        .clk          (clk),
        .reset_n      (reset_n),
        .pwo_enable_i (pwo_enable),
        .pwo_mode_i   (pwo_mode),
        .accumulate_i (accumulate),
        .a_base_i     (a_base),
        .b_base_i     (b_base),
        .c_base_i     (c_base),
        .a_rd_data_i  (a_rd_data),
        .b_rd_data_i  (b_rd_data),
        .c_rd_data_i  (c_rd_data),
        .a_rd_req_o   (a_rd_req),
        .b_rd_req_o   (b_rd_req),
        .c_rd_req_o   (c_rd_req),
        .c_wr_req_o   (c_wr_req),
        .c_wr_data_o  (c_wr_data),
        .busy_o       (busy),
        .done_o       (done)
    );

    task automatic check_value(input string name, input logic [95:0] got,
                               input logic [95:0] exp);
        if (got !== exp) begin
            $display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
            $display("TEST FAIL");
            $fatal(1, "Value mismatch");
        end
    endtask

    // ======================================================================
    // Memory models with one cycle of read latency
    always @(posedge clk) begin : mem_model
        pwo_pkg::pwo_mem_req_t a_req;
        pwo_pkg::pwo_mem_req_t b_req;
        pwo_pkg::pwo_mem_req_t c_req;
        a_req = a_rd_req;
        b_req = b_rd_req;
        c_req = c_rd_req;
        if (c_wr_req.rd_wr_en == pwo_pkg::RW_WRITE) begin
            check_value("c_wr_req_o.addr upper bits", 96'(c_wr_req.addr >> 9), 96'd0);
            c_mem[c_wr_req.addr[8:0]] = c_wr_data;
            wr_count++;
        end
        #1;
        if (a_req.rd_wr_en == pwo_pkg::RW_READ) a_rd_data = a_mem[a_req.addr[8:0]];
        if (b_req.rd_wr_en == pwo_pkg::RW_READ) b_rd_data = b_mem[b_req.addr[8:0]];
        if (c_req.rd_wr_en == pwo_pkg::RW_READ) c_rd_data = c_mem[c_req.addr[8:0]];
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > MAX_CYCLES) begin
            $display("Timeout: the runs did not complete within %0d cycles", MAX_CYCLES);
            $display("TEST FAIL");
            $fatal(1, "Timeout");
        end
    end

    // ======================================================================
    // Operand data and reference model
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic make_word(input bit near_top, output logic [95:0] w);
        logic [31:0] v;
        w = '0;
        for (int i = 0; i < 4; i++) begin
            if (near_top) begin
                take_bits(8, v);
                v = 32'(Q - 1) - v;
            end else begin
                take_bits(23, v);
                if (v >= 32'(Q)) v = v - 32'(Q);
            end
            w[i*24 +: 23] = v[22:0];
        end
    endtask

    function automatic longint expect_coeff(input row_t r, input longint a,
                                            input longint b, input longint c);
        case (r.mode)
            pwo_pkg::PWO_PWA: return (a + b) % Q;
            pwo_pkg::PWO_PWS: return (b > a) ? (a - b + Q) : (a - b);
            default:          return ((a * b) % Q + (r.acc ? c : 64'd0)) % Q;
        endcase
    endfunction

    // Target range against the model and all other words unchanged
    task automatic check_results(input row_t r);
        logic [95:0] exp_w;
        int          k;
        for (int addr = 0; addr < DEPTH; addr++) begin
            k = addr - int'(r.c_base);
            if (k >= 0 && k < NUM_WORDS) begin
                exp_w = '0;
                for (int i = 0; i < 4; i++) begin
                    exp_w[i*24 +: 23] = 23'(expect_coeff(r, a_mem[r.a_base + k][i*24 +: 23],
                        b_mem[r.b_base + k][i*24 +: 23], c_old[addr][i*24 +: 23]));
                end
                check_value($sformatf("c_mem[0x%0h]", addr), c_mem[addr], exp_w);
            end else begin
                check_value($sformatf("c_mem[0x%0h] outside run", addr), c_mem[addr],
                            c_old[addr]);
            end
        end
    endtask

    task automatic run_row(input row_t r);
        int n;
        c_old      = c_mem;
        wr_count   = 0;
        pwo_mode   = r.mode;
        accumulate = r.acc;
        a_base     = r.a_base;
        b_base     = r.b_base;
        c_base     = r.c_base;
        pwo_enable = 1'b1;
        @(posedge clk);
        #1;
        n = 1;
        while (!done) begin
            check_value("busy_o", 96'(busy), 96'd1);
            // Second enable while busy must not restart
            pwo_enable = (n == 5);
            @(posedge clk);
            #1;
            n++;
        end
        check_value("done_o cycle", 96'(n), 96'(DONE_CYCLE));
        check_value("busy_o at done_o", 96'(busy), 96'd0);
        check_value("c write count", 96'(wr_count), 96'(NUM_WORDS));
        check_results(r);
        @(posedge clk);
        #1;
    endtask

    initial begin
        lfsr       = 32'd11719;
        reset_n    = 1'b0;
        pwo_enable = 1'b0;
        pwo_mode   = pwo_pkg::PWO_PWM;
        accumulate = 1'b0;
        a_base     = '0;
        b_base     = '0;
        c_base     = '0;
        a_rd_data  = '0;
        b_rd_data  = '0;
        c_rd_data  = '0;
        wr_count   = 0;
        for (int addr = 0; addr < DEPTH; addr++) begin
            make_word(addr >= 448, a_mem[addr]);
            make_word(addr >= 448, b_mem[addr]);
            make_word(1'b0, c_mem[addr]);
        end
        repeat (4) @(posedge clk);
        #1;
        reset_n = 1'b1;
        @(posedge clk);
        #1;
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(ROWS[r]);
        end
        if (pwo_top_i.u_assert.fail_cnt == 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            $display("Protocol assertions failed %0d times", pwo_top_i.u_assert.fail_cnt);
            $display("TEST FAIL");
            $fatal(1, "Assertion failures");
        end
    end

endmodule

/* project.f */
rtl/pwo_pkg.sv
rtl/pwo_mod_mult.sv
rtl/pwo_lane.sv
rtl/pwo_ctrl.sv
rtl/pwo_top.sv
verif/pwo_tb_assert.sv
verif/pwo_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the pointwise-operation engine testbench with Verilator
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module pwo_tb \
    -f project.f -o pwo_sim \
    && ./obj_dir/pwo_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "TEST FAIL" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "TEST PASS" sim.log || { echo "Simulation did not complete"; exit 1; }
echo "Simulation passed"
